//--- design/memCtrl_config.svh
`ifndef MEMCTRL_CONFIG_SVH
`define MEMCTRL_CONFIG_SVH

// byte address into the RAM
`define MEM_ADDR_WIDTH 17

`define WORD_WIDTH 32

`define BYTE_WIDTH 8

// byte count of one request, 1 2 or 4
`define LEN_WIDTH 3

`endif

//--- design/memCtrlPkg.sv
`default_nettype none

`include "memCtrl_config.svh"

package memCtrlPkg;

    // current user of the RAM port
    typedef enum logic [1:0] {
        ownerIdle = 2'd0,
        ownerData = 2'd1,
        ownerInst = 2'd2
    } busOwner_e;

    typedef enum logic [1:0] {
        kindInstRead  = 2'd0,
        kindDataLoad  = 2'd1,
        kindDataStore = 2'd2
    } accessKind_e;

    // lane 0 is the byte at the lowest address
    typedef union packed {
        logic [`WORD_WIDTH-1:0] word;
        logic [`WORD_WIDTH/`BYTE_WIDTH-1:0][`BYTE_WIDTH-1:0] lanes;
    } memWord_u;

endpackage

`default_nettype wire

//--- design/requestArbiter.sv
`default_nettype none

`include "memCtrl_config.svh"

module requestArbiter (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             advance,
    input  wire                             dataEn,
    input  wire                             dataStore,
    input  wire [`LEN_WIDTH-1:0]            dataLen,
    input  wire [`MEM_ADDR_WIDTH-1:0]       dataAddr,
    input  wire [`WORD_WIDTH-1:0]           dataWrite,
    input  wire                             fetchEn,
    input  wire [`MEM_ADDR_WIDTH-1:0]       fetchAddr,
    input  wire                             reqRetire,
    output logic                            reqStart,
    output memCtrlPkg::accessKind_e         reqKind,
    output logic [`MEM_ADDR_WIDTH-1:0]      reqAddr,
    output logic [`LEN_WIDTH-1:0]           reqLen,
    output logic [`WORD_WIDTH-1:0]          reqWord,
    output memCtrlPkg::busOwner_e           busOwner
);

    logic idle;

    assign idle = (busOwner == memCtrlPkg::ownerIdle);

    // owner stays set until the assembler retires the request,
    // so an enable that is still high is not taken twice
    always_ff @(posedge clk) begin
        if (rst) begin
            busOwner <= memCtrlPkg::ownerIdle;
            reqStart <= 1'b0;
        end else if (advance) begin
            reqStart <= 1'b0;
            if (idle) begin
                if (dataEn) begin
                    busOwner <= memCtrlPkg::ownerData;
                    reqStart <= 1'b1;
                end else if (fetchEn) begin
                    busOwner <= memCtrlPkg::ownerInst;
                    reqStart <= 1'b1;
                end
            end else if (reqRetire) begin
                busOwner <= memCtrlPkg::ownerIdle;
            end
        end
    end

    // data side wins a tie
    always_ff @(posedge clk) begin
        if (advance && idle) begin
            if (dataEn) begin
                reqKind <= dataStore ? memCtrlPkg::kindDataStore : memCtrlPkg::kindDataLoad;
                reqAddr <= dataAddr;
                reqLen  <= dataLen;
                reqWord <= dataWrite;
            end else if (fetchEn) begin
                reqKind <= memCtrlPkg::kindInstRead;
                reqAddr <= fetchAddr;
                // whole instruction
                reqLen  <= `LEN_WIDTH'(4);
                reqWord <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/byteSequencer.sv
`default_nettype none

`include "memCtrl_config.svh"

module byteSequencer (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             advance,
    input  wire                             reqStart,
    input  wire memCtrlPkg::accessKind_e    reqKind,
    input  wire [`MEM_ADDR_WIDTH-1:0]       reqAddr,
    input  wire [`LEN_WIDTH-1:0]            reqLen,
    input  wire [`WORD_WIDTH-1:0]           reqWord,
    output logic [`MEM_ADDR_WIDTH-1:0]      memAddr,
    output logic                            memRw,
    output logic [`BYTE_WIDTH-1:0]          memDataOut,
    output logic                            readIssued,
    output logic [LaneBits-1:0]             issueLane,
    output logic                            lastIssued,
    output memCtrlPkg::accessKind_e         seqKind,
    output logic                            storeFinished
);

    localparam int LaneBits = $clog2(`WORD_WIDTH / `BYTE_WIDTH);

    logic                           active;
    logic [`LEN_WIDTH-1:0]          count;
    logic [`MEM_ADDR_WIDTH-1:0]     baseAddr;
    logic [`LEN_WIDTH-1:0]          len;
    memCtrlPkg::accessKind_e        kind;
    memCtrlPkg::memWord_u           heldWord;

    logic                           issuing;
    logic [`LEN_WIDTH-1:0]          idx;
    logic [`LEN_WIDTH-1:0]          curLen;
    logic [`MEM_ADDR_WIDTH-1:0]     curBase;
    memCtrlPkg::memWord_u           curWord;
    logic                           isStore;

    // byte 0 goes out in the strobe cycle straight from the arbiter fields
    always_comb begin
        issuing      = reqStart || active;
        idx          = reqStart ? '0 : count;
        curLen       = reqStart ? reqLen : len;
        curBase      = reqStart ? reqAddr : baseAddr;
        seqKind      = reqStart ? reqKind : kind;
        curWord.word = reqStart ? reqWord : heldWord.word;
        isStore      = (seqKind == memCtrlPkg::kindDataStore);

        // in a stall the RAM keeps re-reading the byte the assembler still waits for
        memAddr    = curBase + `MEM_ADDR_WIDTH'(advance ? idx : idx - 1'b1);
        issueLane  = idx[LaneBits-1:0];
        memDataOut = curWord.lanes[issueLane];
        lastIssued = issuing && ((idx + 1'b1) == curLen);

        // stalled cycles never write
        memRw         = issuing && advance && isStore;
        readIssued    = issuing && advance && !isStore;
        storeFinished = memRw && lastIssued;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            count  <= '0;
        end else if (advance && issuing) begin
            active <= !lastIssued;
            count  <= idx + 1'b1;
        end
    end

    // request copy for the bytes after the first
    always_ff @(posedge clk) begin
        if (advance && reqStart) begin
            baseAddr      <= reqAddr;
            len           <= reqLen;
            kind          <= reqKind;
            heldWord.word <= reqWord;
        end
    end

endmodule

`default_nettype wire

//--- design/responseAssembler.sv
`default_nettype none

`include "memCtrl_config.svh"

module responseAssembler (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             advance,
    input  wire                             readIssued,
    input  wire [LaneBits-1:0]              issueLane,
    input  wire                             lastIssued,
    input  wire memCtrlPkg::accessKind_e    seqKind,
    input  wire                             storeFinished,
    input  wire [`BYTE_WIDTH-1:0]           memDataIn,
    output logic                            fetchDone,
    output logic [`WORD_WIDTH-1:0]          fetchInst,
    output logic                            dataDone,
    output logic [`WORD_WIDTH-1:0]          dataRead,
    output logic                            reqRetire
);

    localparam int LaneBits = $clog2(`WORD_WIDTH / `BYTE_WIDTH);

    // read issued last advancing cycle, its byte is on memDataIn now
    logic                           pendValid;
    logic                           pendLast;
    logic [LaneBits-1:0]            pendLane;
    memCtrlPkg::accessKind_e        pendKind;

    memCtrlPkg::memWord_u           gathered;
    memCtrlPkg::memWord_u           merged;

    // lane 0 starts a new word, which leaves the upper lanes zero on short loads
    always_comb begin
        merged = gathered;
        if (pendLane == '0) begin
            merged.word = '0;
        end
        merged.lanes[pendLane] = memDataIn;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pendValid <= 1'b0;
            pendLast  <= 1'b0;
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
            reqRetire <= 1'b0;
        end else if (advance) begin
            pendValid <= readIssued;
            pendLast  <= readIssued && lastIssued;
            fetchDone <= pendLast && (pendKind == memCtrlPkg::kindInstRead);
            dataDone  <= (pendLast && (pendKind == memCtrlPkg::kindDataLoad)) || storeFinished;
            reqRetire <= pendLast || storeFinished;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (readIssued) begin
                pendLane <= issueLane;
                pendKind <= seqKind;
            end
            if (pendValid) begin
                gathered <= merged;
            end
            if (pendLast) begin
                if (pendKind == memCtrlPkg::kindInstRead) begin
                    fetchInst <= merged.word;
                end else begin
                    dataRead <= merged.word;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/memCtrl.sv
`default_nettype none

`include "memCtrl_config.svh"

module memCtrl (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             ready,
    input  wire                             ioBufferFull,

    // RAM port
    input  wire [`BYTE_WIDTH-1:0]           memDataIn,
    output logic                            memRw,
    output logic [`MEM_ADDR_WIDTH-1:0]      memAddr,
    output logic [`BYTE_WIDTH-1:0]          memDataOut,

    // instruction fetch
    input  wire                             fetchEn,
    input  wire [`MEM_ADDR_WIDTH-1:0]       fetchAddr,
    output logic                            fetchDone,
    output logic [`WORD_WIDTH-1:0]          fetchInst,

    // data cache
    input  wire                             dataEn,
    input  wire                             dataStore,
    input  wire [`LEN_WIDTH-1:0]            dataLen,
    input  wire [`WORD_WIDTH-1:0]           dataWrite,
    input  wire [`MEM_ADDR_WIDTH-1:0]       dataAddr,
    output logic                            dataDone,
    output logic [`WORD_WIDTH-1:0]          dataRead,

    output memCtrlPkg::busOwner_e           busOwner
);

    localparam int LaneBits = $clog2(`WORD_WIDTH / `BYTE_WIDTH);

    logic                           advance;

    logic                           reqStart;
    memCtrlPkg::accessKind_e        reqKind;
    logic [`MEM_ADDR_WIDTH-1:0]     reqAddr;
    logic [`LEN_WIDTH-1:0]          reqLen;
    logic [`WORD_WIDTH-1:0]         reqWord;

    logic                           readIssued;
    logic [LaneBits-1:0]            issueLane;
    logic                           lastIssued;
    memCtrlPkg::accessKind_e        seqKind;
    logic                           storeFinished;
    logic                           reqRetire;

    // whole controller freezes on either stall level
    assign advance = ready && !ioBufferFull;

    requestArbiter uArbiter (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .reqRetire (reqRetire),
        .reqStart  (reqStart),
        .reqKind   (reqKind),
        .reqAddr   (reqAddr),
        .reqLen    (reqLen),
        .reqWord   (reqWord),
        .busOwner  (busOwner)
    );

    byteSequencer uSequencer (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .reqStart      (reqStart),
        .reqKind       (reqKind),
        .reqAddr       (reqAddr),
        .reqLen        (reqLen),
        .reqWord       (reqWord),
        .memAddr       (memAddr),
        .memRw         (memRw),
        .memDataOut    (memDataOut),
        .readIssued    (readIssued),
        .issueLane     (issueLane),
        .lastIssued    (lastIssued),
        .seqKind       (seqKind),
        .storeFinished (storeFinished)
    );

    responseAssembler uAssembler (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .readIssued    (readIssued),
        .issueLane     (issueLane),
        .lastIssued    (lastIssued),
        .seqKind       (seqKind),
        .storeFinished (storeFinished),
        .memDataIn     (memDataIn),
        .fetchDone     (fetchDone),
        .fetchInst     (fetchInst),
        .dataDone      (dataDone),
        .dataRead      (dataRead),
        .reqRetire     (reqRetire)
    );

endmodule

`default_nettype wire

//--- tb/ramModel.sv
`default_nettype none

`include "memCtrl_config.svh"

module ramModel (
    input  wire                         clk,
    input  wire                         we,
    input  wire [`MEM_ADDR_WIDTH-1:0]   addr,
    input  wire [`BYTE_WIDTH-1:0]       wrData,
    output logic [`BYTE_WIDTH-1:0]      rdData
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int Depth = 1 << `MEM_ADDR_WIDTH;

    // contents are preloaded by the testbench at time zero
    logic [`BYTE_WIDTH-1:0] mem [Depth];

    // read returns the old byte when a write hits the same address
    always @(posedge clk) begin
        rdData <= mem[addr];
        if (we) begin
            mem[addr] = wrData;
        end
    end

endmodule

`default_nettype wire

//--- tb/memCtrlTb.sv
`default_nettype none

`include "memCtrl_config.svh"

module memCtrlTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumRequests = 300;
    // accept, four bytes, response, retire and one spare
    localparam int RequestCycles = 8;
    // stalls never outnumber advancing cycles so the run at most doubles
    localparam int CycleLimit = 2 * NumRequests * RequestCycles + 20;
    localparam int Depth = 1 << `MEM_ADDR_WIDTH;

    logic                           clk;
    logic                           rst;
    logic                           ready;
    logic                           ioBufferFull;
    logic [`BYTE_WIDTH-1:0]         memDataIn;
    logic                           memRw;
    logic [`MEM_ADDR_WIDTH-1:0]     memAddr;
    logic [`BYTE_WIDTH-1:0]         memDataOut;
    logic                           fetchEn;
    logic [`MEM_ADDR_WIDTH-1:0]     fetchAddr;
    logic                           fetchDone;
    logic [`WORD_WIDTH-1:0]         fetchInst;
    logic                           dataEn;
    logic                           dataStore;
    logic [`LEN_WIDTH-1:0]          dataLen;
    logic [`WORD_WIDTH-1:0]         dataWrite;
    logic [`MEM_ADDR_WIDTH-1:0]     dataAddr;
    logic                           dataDone;
    logic [`WORD_WIDTH-1:0]         dataRead;
    memCtrlPkg::busOwner_e          busOwner;

    logic [`BYTE_WIDTH-1:0]         model [Depth];
    int                             cycles;
    int                             stallLeft;
    int                             credit;
    logic                           advancing;
    logic                           storeActive;

    memCtrl i_dut (.*);

    ramModel i_ram (
        .clk    (clk),
        .we     (memRw),
        .addr   (memAddr),
        .wrData (memDataOut),
        .rdData (memDataIn)
    );

    always #10 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [`WORD_WIDTH-1:0] expected,
                              input logic [`WORD_WIDTH-1:0] actual);
        assert (actual === expected)
        else abortRun($sformatf("FAIL %s: expected %08h, actual %08h", name, expected, actual));
    endtask

    // one cycle that returns just after the falling edge where outputs are settled
    task automatic tick();
        logic stall;
        @(negedge clk);
        cycles++;
        if (cycles > CycleLimit) begin
            abortRun("timeout, a request did not finish within the cycle limit");
        end
        assert (!memRw || (advancing && storeActive))
        else abortRun("RAM write strobe was high in a stalled cycle or outside a store");
        // stall stretches of 1 to 3 cycles each paid for by an advancing cycle
        if (stallLeft == 0 && $urandom_range(3) == 0) begin
            stallLeft = 1 + int'($urandom_range(2));
        end
        stall = (stallLeft > 0) && (credit > 0);
        ready = 1'b1;
        ioBufferFull = 1'b0;
        if (stall) begin
            stallLeft--;
            credit--;
            case ($urandom_range(2))
                0: ready = 1'b0;
                1: ioBufferFull = 1'b1;
                default: begin
                    ready = 1'b0;
                    ioBufferFull = 1'b1;
                end
            endcase
        end else begin
            credit++;
        end
        advancing = !stall;
    endtask

    // little endian with the lanes past the length left zero
    function automatic logic [`WORD_WIDTH-1:0] expectedWord(input int addr, input int len);
        logic [`WORD_WIDTH-1:0] word;
        word = '0;
        for (int i = 0; i < len; i++) begin
            word[`BYTE_WIDTH*i +: `BYTE_WIDTH] = model[`MEM_ADDR_WIDTH'(addr + i)];
        end
        return word;
    endfunction

    // mostly a small window so stores and later reads overlap and sometimes the top to wrap
    function automatic int randomAddr();
        if ($urandom_range(7) == 0) begin
            return Depth - 1 - int'($urandom_range(3));
        end
        return int'($urandom_range(127));
    endfunction

    task automatic runRequests(input string name, input bit withData, input bit withFetch,
                               input bit store, input int dAddr, input int len,
                               input logic [`WORD_WIDTH-1:0] wdata, input int fAddr);
        logic [`WORD_WIDTH-1:0] dataExpect;
        memCtrlPkg::busOwner_e  firstOwner;
        dataExpect = expectedWord(dAddr, len);
        firstOwner = memCtrlPkg::ownerIdle;
        // a done pulse held over by a stall belongs to the previous request
        while (dataDone || fetchDone) begin
            tick();
        end
        dataEn = withData;
        dataStore = store;
        dataLen = `LEN_WIDTH'(len);
        dataAddr = `MEM_ADDR_WIDTH'(dAddr);
        dataWrite = wdata;
        fetchEn = withFetch;
        fetchAddr = `MEM_ADDR_WIDTH'(fAddr);
        storeActive = withData && store;
        while (dataEn || fetchEn) begin
            tick();
            if (firstOwner == memCtrlPkg::ownerIdle) begin
                firstOwner = busOwner;
            end
            if (fetchEn && fetchDone) begin
                assert (!dataEn)
                else abortRun("fetch finished ahead of the data request that won arbitration");
                fetchEn = 1'b0;
                checkValue({name, " fetch"}, expectedWord(fAddr, 4), fetchInst);
            end
            if (dataEn && dataDone) begin
                dataEn = 1'b0;
                storeActive = 1'b0;
                if (store) begin
                    for (int i = 0; i < len; i++) begin
                        model[`MEM_ADDR_WIDTH'(dAddr + i)] = wdata[`BYTE_WIDTH*i +: `BYTE_WIDTH];
                    end
                end else begin
                    checkValue({name, " load"}, dataExpect, dataRead);
                end
            end
        end
        checkValue({name, " owner"},
                   withData ? 32'(memCtrlPkg::ownerData) : 32'(memCtrlPkg::ownerInst),
                   32'(firstOwner));
    endtask

    initial begin
        int issued;
        int pick;
        int addr;
        int len;
        logic [`WORD_WIDTH-1:0] wdata;

        void'($urandom(59));
        clk = 1'b0;
        rst = 1'b1;
        ready = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = `LEN_WIDTH'(1);
        dataWrite = '0;
        dataAddr = '0;
        cycles = 0;
        stallLeft = 0;
        credit = 0;
        advancing = 1'b1;
        storeActive = 1'b0;

        // RAM and model start with the same random contents
        for (int a = 0; a < Depth; a++) begin
            model[`MEM_ADDR_WIDTH'(a)] = `BYTE_WIDTH'($urandom());
            i_ram.mem[`MEM_ADDR_WIDTH'(a)] = model[`MEM_ADDR_WIDTH'(a)];
        end

        repeat (2) @(negedge clk);
        rst = 1'b0;
        checkValue("reset fetchDone", '0, 32'(fetchDone));
        checkValue("reset dataDone", '0, 32'(dataDone));
        checkValue("reset memRw", '0, 32'(memRw));
        checkValue("reset busOwner", 32'(memCtrlPkg::ownerIdle), 32'(busOwner));

        issued = 0;
        while (issued < NumRequests) begin
            pick = int'($urandom_range(3));
            addr = randomAddr();
            len = 1 << $urandom_range(2);
            wdata = $urandom();
            case (pick)
                0: runRequests("fetch", 1'b0, 1'b1, 1'b0, 0, 4, '0, addr);
                1: runRequests("load", 1'b1, 1'b0, 1'b0, addr, len, '0, 0);
                2: begin
                    runRequests("store", 1'b1, 1'b0, 1'b1, addr, len, wdata, 0);
                    runRequests("load after store", 1'b1, 1'b0, 1'b0, addr, len, '0, 0);
                end
                default: runRequests("data and fetch together", 1'b1, 1'b1,
                                     $urandom_range(1) == 1, addr, len, wdata, randomAddr());
            endcase
            issued += (pick < 2) ? 1 : 2;
        end

        // whole RAM against the model
        for (int a = 0; a < Depth; a++) begin
            assert (i_ram.mem[`MEM_ADDR_WIDTH'(a)] === model[`MEM_ADDR_WIDTH'(a)])
            else abortRun($sformatf("FAIL ram sweep at %05h: expected %02h, actual %02h",
                                    a, model[`MEM_ADDR_WIDTH'(a)],
                                    i_ram.mem[`MEM_ADDR_WIDTH'(a)]));
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/memCtrlPkg.sv
design/requestArbiter.sv
design/byteSequencer.sv
design/responseAssembler.sv
design/memCtrl.sv
tb/ramModel.sv
tb/memCtrlTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module memCtrlTb -o memCtrlSim
./obj_dir/memCtrlSim | tee sim.log

if grep -q "Simulation passed" sim.log; then
    echo "run ok"
else
    echo "run not ok, see sim.log"
    exit 1
fi
